// ==== rv_pkg.sv ====
package rv_pkg;

    // datapath and register file widths
    localparam int WORD_LEN   = 32;
    localparam int REG_ADDR_W = 5;

    // on-chip memory depths in words
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int MEM_IDX_W  = $clog2(IMEM_WORDS);

    // pc value at which the core stops
    localparam logic [WORD_LEN-1:0] EXIT_PC = WORD_LEN'(IMEM_WORDS * 4);

    // funct3 values
    localparam logic [2:0] F3_WORD   = 3'b010;
    localparam logic [2:0] F3_ADDSUB = 3'b000;

    // funct7 values
    localparam logic [6:0] F7_ADD = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // major opcodes of the supported instructions
    typedef enum logic [6:0] {
        OPC_LOAD  = 7'b0000011,
        OPC_STORE = 7'b0100011,
        OPC_OP    = 7'b0110011
    } opcode_e;

    // decoded instruction kind
    typedef enum logic [2:0] {
        INST_NOP = 3'd0,
        INST_LW  = 3'd1,
        INST_SW  = 3'd2,
        INST_ADD = 3'd3,
        INST_SUB = 3'd4
    } inst_kind_e;

    // decoder output to execute unit and core
    typedef struct packed {
        inst_kind_e            kind;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        // sign-extended, I or S form by kind
        logic [WORD_LEN-1:0]   imm;
        logic                  reg_we;
        logic                  mem_we;
        logic                  wb_from_mem;
    } ctrl_t;

endpackage

// ==== rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
    input  logic [31:0]   inst_i,
    output rv_pkg::ctrl_t ctrl_o
);

    rv_pkg::opcode_e            opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [rv_pkg::WORD_LEN-1:0] imm_i_sext;
    logic [rv_pkg::WORD_LEN-1:0] imm_s_sext;
    rv_pkg::inst_kind_e         kind;

    assign opcode = rv_pkg::opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // I form for loads, S form splits the offset around rd
    assign imm_i_sext = {{(rv_pkg::WORD_LEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s_sext = {{(rv_pkg::WORD_LEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};

    always_comb begin
        kind = rv_pkg::INST_NOP;
        case (opcode)
            rv_pkg::OPC_LOAD: begin
                if (funct3 == rv_pkg::F3_WORD) begin
                    kind = rv_pkg::INST_LW;
                end
            end
            rv_pkg::OPC_STORE: begin
                if (funct3 == rv_pkg::F3_WORD) begin
                    kind = rv_pkg::INST_SW;
                end
            end
            rv_pkg::OPC_OP: begin
                if (funct3 == rv_pkg::F3_ADDSUB && funct7 == rv_pkg::F7_ADD) begin
                    kind = rv_pkg::INST_ADD;
                end else if (funct3 == rv_pkg::F3_ADDSUB && funct7 == rv_pkg::F7_SUB) begin
                    kind = rv_pkg::INST_SUB;
                end
            end
            default: begin
                kind = rv_pkg::INST_NOP;
            end
        endcase
    end

    always_comb begin
        ctrl_o.kind = kind;
        ctrl_o.rs1  = inst_i[19:15];
        ctrl_o.rs2  = inst_i[24:20];
        ctrl_o.rd   = inst_i[11:7];
        ctrl_o.imm  = (kind == rv_pkg::INST_SW) ? imm_s_sext : imm_i_sext;

        // anything unrecognised retires with no side effects
        ctrl_o.reg_we      = (kind == rv_pkg::INST_LW) || (kind == rv_pkg::INST_ADD)
                             || (kind == rv_pkg::INST_SUB);
        ctrl_o.mem_we      = (kind == rv_pkg::INST_SW);
        ctrl_o.wb_from_mem = (kind == rv_pkg::INST_LW);
    end

    // a store never also writes back
    always_comb begin
        assert final (!(ctrl_o.reg_we && ctrl_o.mem_we))
            else $error("decoder: reg_we and mem_we both set for inst %h", inst_i);
    end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          we_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv_pkg::WORD_LEN-1:0]   wdata_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [rv_pkg::WORD_LEN-1:0]   rdata1_o,
    output logic [rv_pkg::WORD_LEN-1:0]   rdata2_o
);

    localparam int NUM_REGS = 2 ** rv_pkg::REG_ADDR_W;

    logic [rv_pkg::WORD_LEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            // x0 writes dropped here
            regs[waddr_i] <= wdata_i;
        end
    end

    // async reads, old value on same-cycle write
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
    input  rv_pkg::ctrl_t               ctrl_i,
    input  logic [rv_pkg::WORD_LEN-1:0] rs1_data_i,
    input  logic [rv_pkg::WORD_LEN-1:0] rs2_data_i,
    output logic [rv_pkg::WORD_LEN-1:0] result_o
);

    logic [rv_pkg::WORD_LEN-1:0] op_b;

    // memory ops add the offset, register ops use rs2
    always_comb begin
        case (ctrl_i.kind)
            rv_pkg::INST_LW,
            rv_pkg::INST_SW: begin
                op_b = ctrl_i.imm;
            end
            default: begin
                op_b = rs2_data_i;
            end
        endcase
    end

    always_comb begin
        if (ctrl_i.kind == rv_pkg::INST_SUB) begin
            result_o = rs1_data_i - op_b;
        end else begin
            // also the address for lw and sw
            result_o = rs1_data_i + op_b;
        end
    end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        run_i,
    output logic [rv_pkg::WORD_LEN-1:0] imem_addr_o,
    input  logic [rv_pkg::WORD_LEN-1:0] imem_data_i,
    output logic [rv_pkg::WORD_LEN-1:0] dmem_addr_o,
    output logic                        dmem_we_o,
    output logic [rv_pkg::WORD_LEN-1:0] dmem_wdata_o,
    input  logic [rv_pkg::WORD_LEN-1:0] dmem_rdata_i,
    output logic                        exit_o
);

    logic [rv_pkg::WORD_LEN-1:0] pc_q;
    logic                        advance;
    rv_pkg::ctrl_t               ctrl;
    logic [rv_pkg::WORD_LEN-1:0] rs1_data;
    logic [rv_pkg::WORD_LEN-1:0] rs2_data;
    logic [rv_pkg::WORD_LEN-1:0] alu_result;
    logic [rv_pkg::WORD_LEN-1:0] wb_data;
    logic                        reg_we;

    assign exit_o      = (pc_q == rv_pkg::EXIT_PC);
    // nothing retires while stalled or finished
    assign advance     = run_i && !exit_o;
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (advance) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    rv_decoder u_decoder (
        .inst_i (imem_data_i),
        .ctrl_o (ctrl)
    );

    assign reg_we = ctrl.reg_we && advance;

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .we_i     (reg_we),
        .waddr_i  (ctrl.rd),
        .wdata_i  (wb_data),
        .raddr1_i (ctrl.rs1),
        .raddr2_i (ctrl.rs2),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    rv_execute u_execute (
        .ctrl_i     (ctrl),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .result_o   (alu_result)
    );

    // data memory port
    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rs2_data;
    assign dmem_we_o    = ctrl.mem_we && advance;

    assign wb_data = ctrl.wb_from_mem ? dmem_rdata_i : alu_result;

    // pc only ever moves by 4 from 0
    pc_aligned_a : assert property (@(posedge clk) disable iff (!rst_n)
        pc_q[1:0] == 2'b00)
        else $error("core: pc %h not word aligned", pc_q);

endmodule

// ==== rv_imem.sv ====
`timescale 1ns/1ps

module rv_imem (
    input  logic                        clk,
    input  logic                        load_we_i,
    input  logic [rv_pkg::WORD_LEN-1:0] load_addr_i,
    input  logic [rv_pkg::WORD_LEN-1:0] load_data_i,
    input  logic [rv_pkg::WORD_LEN-1:0] addr_i,
    output logic [rv_pkg::WORD_LEN-1:0] data_o
);

    logic [rv_pkg::WORD_LEN-1:0]  mem [rv_pkg::IMEM_WORDS];
    logic [rv_pkg::MEM_IDX_W-1:0] load_idx;
    logic [rv_pkg::MEM_IDX_W-1:0] rd_idx;

    // byte addresses, drop the low two bits
    assign load_idx = load_addr_i[rv_pkg::MEM_IDX_W+1:2];
    assign rd_idx   = addr_i[rv_pkg::MEM_IDX_W+1:2];

    // load port, survives reset
    always_ff @(posedge clk) begin
        if (load_we_i) begin
            mem[load_idx] <= load_data_i;
        end
    end

    assign data_o = mem[rd_idx];

endmodule

// ==== rv_dmem.sv ====
`timescale 1ns/1ps

module rv_dmem (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we_i,
    input  logic [rv_pkg::WORD_LEN-1:0] addr_i,
    input  logic [rv_pkg::WORD_LEN-1:0] wdata_i,
    output logic [rv_pkg::WORD_LEN-1:0] rdata_o
);

    logic [rv_pkg::WORD_LEN-1:0]  mem [rv_pkg::DMEM_WORDS];
    logic [rv_pkg::MEM_IDX_W-1:0] idx;

    assign idx = addr_i[rv_pkg::MEM_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // unwritten words read back as zero
            for (int i = 0; i < rv_pkg::DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[idx] <= wdata_i;
        end
    end

    // old data on a same-cycle write
    assign rdata_o = mem[idx];

    // only whole-word stores reach this memory
    store_aligned_a : assert property (@(posedge clk) disable iff (!rst_n)
        we_i |-> addr_i[1:0] == 2'b00)
        else $error("dmem: misaligned store to %h", addr_i);

endmodule

// ==== rv_top.sv ====
`timescale 1ns/1ps

module rv_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        run_i,
    input  logic                        imem_load_we_i,
    input  logic [rv_pkg::WORD_LEN-1:0] imem_load_addr_i,
    input  logic [rv_pkg::WORD_LEN-1:0] imem_load_data_i,
    output logic                        dmem_we_o,
    output logic [rv_pkg::WORD_LEN-1:0] dmem_addr_o,
    output logic [rv_pkg::WORD_LEN-1:0] dmem_wdata_o,
    output logic                        exit_o
);

    logic [rv_pkg::WORD_LEN-1:0] imem_addr;
    logic [rv_pkg::WORD_LEN-1:0] imem_data;
    logic [rv_pkg::WORD_LEN-1:0] dmem_rdata;

    rv_core u_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .run_i        (run_i),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_rdata_i (dmem_rdata),
        .exit_o       (exit_o)
    );

    rv_imem u_imem (
        .clk         (clk),
        .load_we_i   (imem_load_we_i),
        .load_addr_i (imem_load_addr_i),
        .load_data_i (imem_load_data_i),
        .addr_i      (imem_addr),
        .data_o      (imem_data)
    );

    // store strobe also goes out for observation
    rv_dmem u_dmem (
        .clk     (clk),
        .rst_n   (rst_n),
        .we_i    (dmem_we_o),
        .addr_i  (dmem_addr_o),
        .wdata_i (dmem_wdata_o),
        .rdata_o (dmem_rdata)
    );

endmodule

// ==== tb_rv_top.sv ====
`timescale 1ns/1ps

module tb_rv_top;

    localparam int NUM_PROGS      = 6;
    localparam int PROG_WORDS     = rv_pkg::IMEM_WORDS;
    localparam int TIMEOUT_CYCLES = (NUM_PROGS * (64 + 64 + 10)) * 2;
    localparam int STALL_AT       = 20;
    localparam int STALL_CYCLES   = 3;
    localparam int DRIVE_DELAY    = 1;

    logic        clk;
    logic        rst_n;
    logic        run;
    logic        load_we;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        core_exit;

    logic [31:0] lcg_state;
    logic [31:0] prog [PROG_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [rv_pkg::DMEM_WORDS];
    logic [31:0] model_pc;
    int          prog_num;
    int          cycle_count = 0;

    rv_top DUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .run_i            (run),
        .imem_load_we_i   (load_we),
        .imem_load_addr_i (load_addr),
        .imem_load_data_i (load_data),
        .dmem_we_o        (dmem_we),
        .dmem_addr_o      (dmem_addr),
        .dmem_wdata_o     (dmem_wdata),
        .exit_o           (core_exit)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("TEST FAIL");
            $fatal(1, "timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        // low bits of an LCG are weak
        return int'(r[31:8]) % n;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_load(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm, input logic [2:0] f3);
        return {imm, rs1, f3, rd, rv_pkg::OPC_LOAD};
    endfunction

    function automatic logic [31:0] enc_store(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    // words outside the supported set such as mul, lb, sh and addi
    function automatic logic [31:0] gen_illegal(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
        logic [31:0] w;
        w = lcg_next();
        case (rand_below(4))
            0: return enc_r(7'b0000001, rs2, rs1, rv_pkg::F3_ADDSUB, rd);
            1: return enc_load(rd, rs1, w[11:0], 3'b000);
            2: return enc_store(rs2, rs1, w[11:0], 3'b001);
            default: return {w[31:7], 7'b0010011};
        endcase
    endfunction

    function automatic logic [31:0] gen_inst();
        int          sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] off;
        sel = rand_below(10);
        rd  = 5'(rand_below(16));
        rs1 = 5'(rand_below(16));
        rs2 = 5'(rand_below(16));
        // small window so loads often hit earlier stores
        off = 12'(rand_below(32) * 4);
        case (sel)
            0, 1, 2: return enc_r(rv_pkg::F7_ADD, rs2, rs1, rv_pkg::F3_ADDSUB, rd);
            3, 4:    return enc_r(rv_pkg::F7_SUB, rs2, rs1, rv_pkg::F3_ADDSUB, rd);
            5, 6:    return enc_store(rs2, 5'd0, off, rv_pkg::F3_WORD);
            7, 8:    return enc_load(rd, 5'd0, off, rv_pkg::F3_WORD);
            default: return gen_illegal(rd, rs1, rs2);
        endcase
    endfunction

    task automatic build_program();
        for (int i = 0; i < PROG_WORDS - 15; i++) begin
            prog[i] = gen_inst();
        end
        // dump x1..x15 to words 48..62
        for (int j = 1; j <= 15; j++) begin
            prog[PROG_WORDS - 16 + j] = enc_store(5'(j), 5'd0, 12'(192 + (j - 1) * 4),
                                                  rv_pkg::F3_WORD);
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < rv_pkg::DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        model_pc = '0;
    endtask

    // one instruction of the reference model and its expected store
    task automatic model_step(output logic exp_we, output logic [31:0] exp_addr,
                              output logic [31:0] exp_wdata);
        logic [31:0] inst;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        inst = prog[model_pc[31:2]];
        opc  = inst[6:0];
        f3   = inst[14:12];
        f7   = inst[31:25];
        rd   = inst[11:7];
        a    = (inst[19:15] == 5'd0) ? 32'd0 : model_regs[inst[19:15]];
        b    = (inst[24:20] == 5'd0) ? 32'd0 : model_regs[inst[24:20]];
        exp_we    = 1'b0;
        exp_addr  = '0;
        exp_wdata = '0;
        if (opc == rv_pkg::OPC_LOAD && f3 == rv_pkg::F3_WORD) begin
            ea = a + {{20{inst[31]}}, inst[31:20]};
            if (rd != 5'd0) begin
                model_regs[rd] = model_mem[ea[7:2]];
            end
        end else if (opc == rv_pkg::OPC_STORE && f3 == rv_pkg::F3_WORD) begin
            ea = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
            exp_we    = 1'b1;
            exp_addr  = ea;
            exp_wdata = b;
            model_mem[ea[7:2]] = b;
        end else if (opc == rv_pkg::OPC_OP && f3 == rv_pkg::F3_ADDSUB && rd != 5'd0) begin
            if (f7 == rv_pkg::F7_ADD) begin
                model_regs[rd] = a + b;
            end else if (f7 == rv_pkg::F7_SUB) begin
                model_regs[rd] = a - b;
            end
        end
        model_pc = model_pc + 32'd4;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h (program %0d, pc %h)",
                     name, got, exp, prog_num, model_pc);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_outputs(input logic exp_we, input logic [31:0] exp_addr,
                                 input logic [31:0] exp_wdata, input logic exp_exit);
        check_value("exit_o", {31'b0, core_exit}, {31'b0, exp_exit});
        check_value("dmem_we_o", {31'b0, dmem_we}, {31'b0, exp_we});
        if (exp_we) begin
            check_value("dmem_addr_o", dmem_addr, exp_addr);
            check_value("dmem_wdata_o", dmem_wdata, exp_wdata);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            load_we   = 1'b1;
            load_addr = 32'(i * 4);
            load_data = prog[i];
            @(negedge clk);
            check_value("dmem_we_o", {31'b0, dmem_we}, 32'd0);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        load_we = 1'b0;
    endtask

    // imem keeps its contents while the rest of the core restarts
    task automatic pulse_reset();
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        model_reset();
    endtask

    task automatic run_program();
        logic        exp_we;
        logic [31:0] exp_addr;
        logic [31:0] exp_wdata;
        int          stall_left;
        stall_left = STALL_CYCLES;
        @(posedge clk);
        #DRIVE_DELAY;
        run = 1'b1;
        while (model_pc != rv_pkg::EXIT_PC) begin
            @(negedge clk);
            if (run) begin
                model_step(exp_we, exp_addr, exp_wdata);
                check_outputs(exp_we, exp_addr, exp_wdata, 1'b0);
            end else begin
                check_outputs(1'b0, '0, '0, 1'b0);
            end
            @(posedge clk);
            #DRIVE_DELAY;
            if (model_pc == 32'(STALL_AT * 4) && stall_left > 0) begin
                run = 1'b0;
                stall_left--;
            end else begin
                run = 1'b1;
            end
        end
        // run stays high and the core must hold
        repeat (3) begin
            @(negedge clk);
            check_outputs(1'b0, '0, '0, 1'b1);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        run = 1'b0;
    endtask

    initial begin
        lcg_state = 32'h3be5_1d42;
        rst_n     = 1'b0;
        run       = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        prog_num  = 0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        for (int p = 0; p < NUM_PROGS; p++) begin
            prog_num = p;
            build_program();
            load_program();
            pulse_reset();
            run_program();
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_core.sv
rv_imem.sv
rv_dmem.sv
rv_top.sv
tb_rv_top.sv
